//--- hdl/apu_pkg.sv
package apu_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Default operand and result width
  parameter int DATA_W   = 16;
  parameter int REG_AW   = 6;
  parameter int NUM_REGS = 64;

  // One divider iteration per quotient bit
  parameter int DIV_CYCLES = DATA_W;

  ////////////////////
  // Encodings
  ////////////////////

  typedef enum logic [2:0] {
    LDI  = 3'd0,
    ADD  = 3'd1,
    MUL  = 3'd2,
    MULH = 3'd3,
    DIVU = 3'd4
  } opcode_e;

  // Latency class of an accelerator operation
  typedef enum logic [1:0] {
    LAT0 = 2'd0,
    LAT1 = 2'd1,
    LAT2 = 2'd2,
    LAT3 = 2'd3
  } lat_e;

  // Instruction fields, bits 31 to 21 are unused
  parameter int OPC_LSB = 0;
  parameter int OPC_MSB = 2;
  parameter int RD_LSB  = 3;
  parameter int RD_MSB  = 8;
  parameter int RS1_LSB = 9;
  parameter int RS1_MSB = 14;
  parameter int RS2_LSB = 15;
  parameter int RS2_MSB = 20;
  parameter int IMM_LSB = 9;
  parameter int IMM_MSB = 20;

endpackage

//--- hdl/apu_decode.sv
`timescale 1ns/100ps

module apu_decode #(
  parameter int DATA_W = apu_pkg::DATA_W
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // Instruction port
  input  logic                              instr_valid_i,
  input  logic [31:0]                       instr_i,
  output logic                              instr_ready_o,
  // Issue stage towards the dispatcher
  output logic                              enable_o,
  output apu_pkg::lat_e                     lat_o,
  output logic [apu_pkg::REG_AW-1:0]        waddr_o,
  input  logic                              stall_i,
  // D stage dependency check
  output logic                              is_decoding_o,
  output logic [1:0][apu_pkg::REG_AW-1:0]   read_regs_o,
  output logic [1:0]                        read_regs_valid_o,
  output logic [0:0][apu_pkg::REG_AW-1:0]   write_regs_o,
  output logic [0:0]                        write_regs_valid_o,
  input  logic                              read_dep_i,
  input  logic                              write_dep_i,
  // Register file read ports
  output logic [apu_pkg::REG_AW-1:0]        raddr_a_o,
  output logic [apu_pkg::REG_AW-1:0]        raddr_b_o,
  input  logic [DATA_W-1:0]                 rdata_a_i,
  input  logic [DATA_W-1:0]                 rdata_b_i,
  // Operation towards the execute unit
  output apu_pkg::opcode_e                  op_o,
  output logic [DATA_W-1:0]                 opa_o,
  output logic [DATA_W-1:0]                 opb_o
);

  logic                        ready_en;
  logic                        d_valid, d_load, d_move;
  logic [31:0]                 d_instr;
  apu_pkg::opcode_e            d_op;
  apu_pkg::lat_e               d_lat;
  logic [apu_pkg::REG_AW-1:0]  d_rd, d_rs1, d_rs2;
  logic [11:0]                 d_imm;
  logic                        i_valid, i_accept;
  apu_pkg::opcode_e            i_op;
  apu_pkg::lat_e               i_lat;
  logic [apu_pkg::REG_AW-1:0]  i_rd;
  logic [DATA_W-1:0]           i_opa, i_opb;

  ////////////////////
  // D stage
  ////////////////////

  assign d_rd  = d_instr[apu_pkg::RD_MSB:apu_pkg::RD_LSB];
  assign d_rs1 = d_instr[apu_pkg::RS1_MSB:apu_pkg::RS1_LSB];
  assign d_rs2 = d_instr[apu_pkg::RS2_MSB:apu_pkg::RS2_LSB];
  assign d_imm = d_instr[apu_pkg::IMM_MSB:apu_pkg::IMM_LSB];

  // Opcode and latency class, undefined opcodes run as ADD
  always_comb begin
    d_op  = apu_pkg::ADD;
    d_lat = apu_pkg::LAT0;
    case (d_instr[apu_pkg::OPC_MSB:apu_pkg::OPC_LSB])
      apu_pkg::LDI:  d_op = apu_pkg::LDI;
      apu_pkg::MUL: begin
        d_op  = apu_pkg::MUL;
        d_lat = apu_pkg::LAT1;
      end
      apu_pkg::MULH: begin
        d_op  = apu_pkg::MULH;
        d_lat = apu_pkg::LAT2;
      end
      apu_pkg::DIVU: begin
        d_op  = apu_pkg::DIVU;
        d_lat = apu_pkg::LAT3;
      end
      default: d_op = apu_pkg::ADD;
    endcase
  end

  // Dependency view of the word held in D
  assign is_decoding_o         = d_valid;
  assign read_regs_o           = {d_rs2, d_rs1};
  // LDI has no source registers
  assign read_regs_valid_o     = {2{d_op != apu_pkg::LDI}};
  assign write_regs_o          = d_rd;
  assign write_regs_valid_o    = 1'b1;
  assign raddr_a_o             = d_rs1;
  assign raddr_b_o             = d_rs2;

  // I frees up on acceptance, D moves once no dependency is left
  assign i_accept      = i_valid & ~stall_i;
  assign d_move        = d_valid & (~i_valid | i_accept) & ~read_dep_i & ~write_dep_i;
  assign d_load        = instr_valid_i & instr_ready_o;
  assign instr_ready_o = ready_en & (~d_valid | d_move);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ready_en <= 1'b0;
      d_valid  <= 1'b0;
      i_valid  <= 1'b0;
    end else begin
      // Port opens one cycle after reset
      ready_en <= 1'b1;
      if (d_load) begin
        d_valid <= 1'b1;
      end else if (d_move) begin
        d_valid <= 1'b0;
      end
      if (d_move) begin
        i_valid <= 1'b1;
      end else if (i_accept) begin
        i_valid <= 1'b0;
      end
    end
  end

  ////////////////////
  // I stage
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (d_load) begin
      d_instr <= instr_i;
    end
    if (d_move) begin
      i_op  <= d_op;
      i_lat <= d_lat;
      i_rd  <= d_rd;
      // Register reads are write-through, so a same-cycle result is caught
      i_opa <= (d_op == apu_pkg::LDI) ? DATA_W'(d_imm) : rdata_a_i;
      i_opb <= (d_op == apu_pkg::LDI) ? '0 : rdata_b_i;
    end
  end

  assign enable_o = i_valid;
  assign lat_o    = i_lat;
  assign waddr_o  = i_rd;
  assign op_o     = i_op;
  assign opa_o    = i_opa;
  assign opb_o    = i_opb;

endmodule

//--- hdl/apu_disp.sv
`timescale 1ns/100ps

module apu_disp #(
  parameter int NUM_RD = 2,
  parameter int NUM_WR = 1
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // Request from the issue stage
  input  logic                                    enable_i,
  input  apu_pkg::lat_e                           apu_lat_i,
  input  logic [apu_pkg::REG_AW-1:0]              apu_waddr_i,
  // Writeback address of the returning result
  output logic [apu_pkg::REG_AW-1:0]              apu_waddr_o,
  output logic                                    active_o,
  output logic                                    stall_o,
  // Dependency checks against the D stage
  input  logic                                    is_decoding_i,
  input  logic [NUM_RD-1:0][apu_pkg::REG_AW-1:0]  read_regs_i,
  input  logic [NUM_RD-1:0]                       read_regs_valid_i,
  output logic                                    read_dep_o,
  input  logic [NUM_WR-1:0][apu_pkg::REG_AW-1:0]  write_regs_i,
  input  logic [NUM_WR-1:0]                       write_regs_valid_i,
  output logic                                    write_dep_o,
  // Stall events
  output logic                                    perf_type_o,
  output logic                                    perf_cont_o,
  // Accelerator handshake
  output logic                                    apu_req_o,
  input  logic                                    apu_gnt_i,
  input  logic                                    apu_rvalid_i
);

  logic [apu_pkg::REG_AW-1:0]  addr_req, addr_inflight, addr_waiting;
  logic [apu_pkg::REG_AW-1:0]  addr_inflight_dn, addr_waiting_dn;
  logic                        valid_req, valid_inflight, valid_waiting;
  logic                        valid_inflight_dn, valid_waiting_dn;
  logic                        returned_req, returned_inflight, returned_waiting;
  logic                        live_req, live_inflight, live_waiting;
  logic                        req_accepted, active;
  apu_pkg::lat_e               apu_lat;
  logic                        read_hit, write_hit;
  logic                        stall_full, stall_type, stall_nack;

  // Request unless a full or type stall holds it back
  assign valid_req    = enable_i & ~(stall_full | stall_type);
  assign addr_req     = apu_waddr_i;
  assign req_accepted = valid_req & apu_gnt_i;

  ////////////////////
  // Outstanding slots
  ////////////////////

  // Waiting is always the older entry and only exists next to an in-flight one
  assign returned_req      = valid_req & apu_rvalid_i & ~valid_inflight & ~valid_waiting;
  assign returned_inflight = valid_inflight & apu_rvalid_i & ~valid_waiting;
  assign returned_waiting  = valid_waiting & apu_rvalid_i;

  always_comb begin
    valid_inflight_dn = valid_inflight & ~returned_inflight;
    valid_waiting_dn  = valid_waiting & ~returned_waiting;
    addr_inflight_dn  = addr_inflight;
    addr_waiting_dn   = addr_waiting;
    // Multicycle request enters in-flight, pushing an older one to waiting
    if (req_accepted && !returned_req) begin
      if (valid_inflight_dn) begin
        valid_waiting_dn = 1'b1;
        addr_waiting_dn  = addr_inflight;
      end
      valid_inflight_dn = 1'b1;
      addr_inflight_dn  = addr_req;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_inflight <= 1'b0;
      valid_waiting  <= 1'b0;
      apu_lat        <= apu_pkg::LAT0;
    end else begin
      valid_inflight <= valid_inflight_dn;
      valid_waiting  <= valid_waiting_dn;
      // Class of the last request
      if (valid_req) begin
        apu_lat <= apu_lat_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    addr_inflight <= addr_inflight_dn;
    addr_waiting  <= addr_waiting_dn;
  end

  assign active   = valid_inflight | valid_waiting;
  assign active_o = active;

  ////////////////////
  // Dependencies
  ////////////////////

  // Entries returning now are already visible through the register file
  assign live_req      = valid_req & ~returned_req;
  assign live_inflight = valid_inflight & ~returned_inflight;
  assign live_waiting  = valid_waiting & ~returned_waiting;

  always_comb begin
    read_hit  = 1'b0;
    write_hit = 1'b0;
    for (int i = 0; i < NUM_RD; i++) begin
      if (read_regs_valid_i[i]) begin
        read_hit |= (live_req      & (read_regs_i[i] == addr_req))
                  | (live_inflight & (read_regs_i[i] == addr_inflight))
                  | (live_waiting  & (read_regs_i[i] == addr_waiting));
      end
    end
    for (int i = 0; i < NUM_WR; i++) begin
      if (write_regs_valid_i[i]) begin
        write_hit |= (live_req      & (write_regs_i[i] == addr_req))
                   | (live_inflight & (write_regs_i[i] == addr_inflight))
                   | (live_waiting  & (write_regs_i[i] == addr_waiting));
      end
    end
  end

  assign read_dep_o  = read_hit & is_decoding_i;
  assign write_dep_o = write_hit & is_decoding_i;

  ////////////////////
  // Stalls
  ////////////////////

  // Both slots taken
  assign stall_full = valid_inflight & valid_waiting;
  // While active, a shorter class would overtake and a divide is never stacked
  assign stall_type = enable_i & active & ((apu_lat_i < apu_lat) | (apu_lat_i == apu_pkg::LAT3));
  // Request raised but not granted
  assign stall_nack = valid_req & ~apu_gnt_i;
  assign stall_o    = stall_full | stall_type | stall_nack;

  assign apu_req_o   = valid_req;
  assign perf_type_o = stall_type;
  assign perf_cont_o = stall_nack;

  // Destination of the result leaving in this cycle
  always_comb begin
    apu_waddr_o = addr_req;
    if (returned_waiting) begin
      apu_waddr_o = addr_waiting;
    end else if (returned_inflight) begin
      apu_waddr_o = addr_inflight;
    end
  end

endmodule

//--- hdl/apu_exec.sv
`timescale 1ns/100ps

module apu_exec #(
  parameter int DATA_W = apu_pkg::DATA_W
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Request handshake
  input  logic               apu_req_i,
  output logic               apu_gnt_o,
  input  apu_pkg::opcode_e   op_i,
  input  logic [DATA_W-1:0]  opa_i,
  input  logic [DATA_W-1:0]  opb_i,
  // Claimed by another user
  input  logic               apu_busy_i,
  // Result channel
  output logic               apu_rvalid_o,
  output logic [DATA_W-1:0]  result_o
);

  localparam int CNT_W = $clog2(DATA_W + 1);

  logic                 accept, fast_op;
  logic [DATA_W-1:0]    fast_res;
  logic [2*DATA_W-1:0]  product;
  logic                 s1_valid, s1_hi, s2_valid;
  logic [2*DATA_W-1:0]  s1_prod;
  logic [DATA_W-1:0]    s2_data;
  logic                 div_busy, div_done;
  logic [CNT_W-1:0]     div_cnt;
  logic [DATA_W-1:0]    div_rem, div_quo, div_dvs;
  logic [DATA_W:0]      rem_shift, rem_diff;

  assign apu_gnt_o = ~apu_busy_i;
  assign accept    = apu_req_i & apu_gnt_o;

  // Class 0 path, returns in the acceptance cycle
  assign fast_op  = (op_i == apu_pkg::LDI) | (op_i == apu_pkg::ADD);
  assign fast_res = (op_i == apu_pkg::LDI) ? opa_i : opa_i + opb_i;

  ////////////////////
  // Multiply pipe
  ////////////////////

  assign product = opa_i * opb_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      s1_valid <= accept & ((op_i == apu_pkg::MUL) | (op_i == apu_pkg::MULH));
      // Only the high half continues to the second stage
      s2_valid <= s1_valid & s1_hi;
    end
  end

  always_ff @(posedge clk_i) begin
    s1_hi   <= (op_i == apu_pkg::MULH);
    s1_prod <= product;
    s2_data <= s1_prod[2*DATA_W-1:DATA_W];
  end

  ////////////////////
  // Divider
  ////////////////////

  // Restoring step, a zero divisor yields an all-ones quotient
  assign rem_shift = {div_rem, div_quo[DATA_W-1]};
  assign rem_diff  = rem_shift - {1'b0, div_dvs};
  assign div_done  = div_busy & (div_cnt == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      div_busy <= 1'b0;
      div_cnt  <= '0;
    end else if (accept && op_i == apu_pkg::DIVU) begin
      div_busy <= 1'b1;
      div_cnt  <= CNT_W'(DATA_W);
    end else if (div_busy) begin
      // Done cycle follows the last iteration
      if (div_cnt != '0) begin
        div_cnt <= div_cnt - 1'b1;
      end else begin
        div_busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && op_i == apu_pkg::DIVU) begin
      div_rem <= '0;
      div_quo <= opa_i;
      div_dvs <= opb_i;
    end else if (div_busy && div_cnt != '0) begin
      div_rem <= rem_diff[DATA_W] ? rem_shift[DATA_W-1:0] : rem_diff[DATA_W-1:0];
      div_quo <= {div_quo[DATA_W-2:0], ~rem_diff[DATA_W]};
    end
  end

  // One source at a time, the dispatcher rules out collisions
  always_comb begin
    apu_rvalid_o = 1'b0;
    result_o     = fast_res;
    if (div_done) begin
      apu_rvalid_o = 1'b1;
      result_o     = div_quo;
    end else if (s2_valid) begin
      apu_rvalid_o = 1'b1;
      result_o     = s2_data;
    end else if (s1_valid && !s1_hi) begin
      apu_rvalid_o = 1'b1;
      result_o     = s1_prod[DATA_W-1:0];
    end else if (accept && fast_op) begin
      apu_rvalid_o = 1'b1;
    end
  end

endmodule

//--- hdl/apu_result.sv
`timescale 1ns/100ps

module apu_result #(
  parameter int DATA_W = apu_pkg::DATA_W
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // Write port from the execute unit
  input  logic                              wvalid_i,
  input  logic [apu_pkg::REG_AW-1:0]        waddr_i,
  input  logic [DATA_W-1:0]                 wdata_i,
  // Read ports of the decode unit
  input  logic [apu_pkg::REG_AW-1:0]        raddr_a_i,
  input  logic [apu_pkg::REG_AW-1:0]        raddr_b_i,
  output logic [DATA_W-1:0]                 rdata_a_o,
  output logic [DATA_W-1:0]                 rdata_b_o,
  // Writeback view
  output logic                              wb_valid_o,
  output logic [apu_pkg::REG_AW-1:0]        wb_addr_o,
  output logic [DATA_W-1:0]                 wb_data_o,
  // Stall counters
  input  logic                              perf_type_i,
  input  logic                              perf_cont_i,
  output logic [15:0]                       perf_type_cnt_o,
  output logic [15:0]                       perf_cont_cnt_o
);

  logic [DATA_W-1:0] regs [apu_pkg::NUM_REGS];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < apu_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
      perf_type_cnt_o <= '0;
      perf_cont_cnt_o <= '0;
    end else begin
      if (wvalid_i) begin
        regs[waddr_i] <= wdata_i;
      end
      // One count per stalled cycle
      if (perf_type_i) begin
        perf_type_cnt_o <= perf_type_cnt_o + 16'd1;
      end
      if (perf_cont_i) begin
        perf_cont_cnt_o <= perf_cont_cnt_o + 16'd1;
      end
    end
  end

  // Write-through so a result landing now is read in the same cycle
  assign rdata_a_o = (wvalid_i && waddr_i == raddr_a_i) ? wdata_i : regs[raddr_a_i];
  assign rdata_b_o = (wvalid_i && waddr_i == raddr_b_i) ? wdata_i : regs[raddr_b_i];

  assign wb_valid_o = wvalid_i;
  assign wb_addr_o  = waddr_i;
  assign wb_data_o  = wdata_i;

endmodule

//--- hdl/apu_subsys_top.sv
`timescale 1ns/100ps

module apu_subsys_top #(
  parameter int DATA_W = apu_pkg::DATA_W,
  parameter int NUM_RD = 2,
  parameter int NUM_WR = 1
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Instruction port
  input  logic                        instr_valid_i,
  input  logic [31:0]                 instr_i,
  output logic                        instr_ready_o,
  // Accelerator claimed elsewhere
  input  logic                        apu_busy_i,
  // Writeback
  output logic                        wb_valid_o,
  output logic [apu_pkg::REG_AW-1:0]  wb_addr_o,
  output logic [DATA_W-1:0]           wb_data_o,
  // Status and counters
  output logic                        apu_active_o,
  output logic [15:0]                 perf_type_cnt_o,
  output logic [15:0]                 perf_cont_cnt_o
);

  logic                                    enable, stall, is_decoding;
  apu_pkg::lat_e                           lat;
  logic [apu_pkg::REG_AW-1:0]              issue_waddr, ret_waddr;
  logic [NUM_RD-1:0][apu_pkg::REG_AW-1:0]  read_regs;
  logic [NUM_RD-1:0]                       read_regs_valid;
  logic [NUM_WR-1:0][apu_pkg::REG_AW-1:0]  write_regs;
  logic [NUM_WR-1:0]                       write_regs_valid;
  logic                                    read_dep, write_dep;
  logic [apu_pkg::REG_AW-1:0]              raddr_a, raddr_b;
  logic [DATA_W-1:0]                       rdata_a, rdata_b, opa, opb, result;
  apu_pkg::opcode_e                        op;
  logic                                    apu_req, apu_gnt, apu_rvalid;
  logic                                    perf_type, perf_cont;

  apu_decode #(.DATA_W(DATA_W)) apu_decode_i (
    .clk_i, .rst_ni, .instr_valid_i, .instr_i, .instr_ready_o,
    .enable_o(enable), .lat_o(lat), .waddr_o(issue_waddr), .stall_i(stall),
    .is_decoding_o(is_decoding), .read_regs_o(read_regs), .read_regs_valid_o(read_regs_valid),
    .write_regs_o(write_regs), .write_regs_valid_o(write_regs_valid),
    .read_dep_i(read_dep), .write_dep_i(write_dep),
    .raddr_a_o(raddr_a), .raddr_b_o(raddr_b), .rdata_a_i(rdata_a), .rdata_b_i(rdata_b),
    .op_o(op), .opa_o(opa), .opb_o(opb)
  );

  apu_disp #(.NUM_RD(NUM_RD), .NUM_WR(NUM_WR)) apu_disp_i (
    .clk_i, .rst_ni, .enable_i(enable), .apu_lat_i(lat), .apu_waddr_i(issue_waddr),
    .apu_waddr_o(ret_waddr), .active_o(apu_active_o), .stall_o(stall),
    .is_decoding_i(is_decoding), .read_regs_i(read_regs), .read_regs_valid_i(read_regs_valid),
    .read_dep_o(read_dep), .write_regs_i(write_regs), .write_regs_valid_i(write_regs_valid),
    .write_dep_o(write_dep), .perf_type_o(perf_type), .perf_cont_o(perf_cont),
    .apu_req_o(apu_req), .apu_gnt_i(apu_gnt), .apu_rvalid_i(apu_rvalid)
  );

  apu_exec #(.DATA_W(DATA_W)) apu_exec_i (
    .clk_i, .rst_ni, .apu_req_i(apu_req), .apu_gnt_o(apu_gnt),
    .op_i(op), .opa_i(opa), .opb_i(opb), .apu_busy_i,
    .apu_rvalid_o(apu_rvalid), .result_o(result)
  );

  apu_result #(.DATA_W(DATA_W)) apu_result_i (
    .clk_i, .rst_ni, .wvalid_i(apu_rvalid), .waddr_i(ret_waddr), .wdata_i(result),
    .raddr_a_i(raddr_a), .raddr_b_i(raddr_b), .rdata_a_o(rdata_a), .rdata_b_o(rdata_b),
    .wb_valid_o, .wb_addr_o, .wb_data_o,
    .perf_type_i(perf_type), .perf_cont_i(perf_cont), .perf_type_cnt_o, .perf_cont_cnt_o
  );

endmodule

//--- tb/apu_tb_clkgen.sv
`timescale 1ns/100ps

module apu_tb_clkgen #(
  parameter int PERIOD_NS  = 8,
  parameter int RST_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_no
);

  // Clock starts low, so reset lifts on a falling edge
  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    #(PERIOD_NS * RST_CYCLES) rst_no = 1'b1;
  end

  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

//--- tb/apu_disp_assertions.sv
`timescale 1ns/100ps

module apu_disp_assertions (
  input logic                        clk_i,
  input logic                        rst_ni,
  input logic                        enable_i,
  input apu_pkg::lat_e               apu_lat_i,
  input logic [apu_pkg::REG_AW-1:0]  apu_waddr_i,
  input logic                        apu_req_i,
  input logic                        apu_gnt_i,
  input logic                        apu_rvalid_i,
  input logic                        stall_i,
  input logic                        valid_inflight_i,
  input logic                        valid_waiting_i
);

  // Number of failed assertions so far
  int          fail_cnt = 0;
  // Operations accepted and not yet returned, counted apart from the slots
  logic [2:0]  pending;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending <= '0;
    end else begin
      pending <= pending + 3'(apu_req_i && apu_gnt_i) - 3'(apu_rvalid_i);
    end
  end

  // A result needs an owner, a slot or a class 0 request accepted now
  ret_has_owner_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    apu_rvalid_i |-> (valid_inflight_i || valid_waiting_i || (apu_req_i && apu_gnt_i))
  ) else begin
    fail_cnt++;
    $error("result returned with nothing outstanding");
  end

  // Stalled request keeps its destination and class until it goes through
  stall_hold_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (enable_i && stall_i) |=> (enable_i && $stable(apu_waddr_i) && $stable(apu_lat_i))
  ) else begin
    fail_cnt++;
    $error("stalled request changed before it was granted");
  end

  // Waiting slot only sits behind an in-flight one
  waiting_order_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    valid_waiting_i |-> valid_inflight_i
  ) else begin
    fail_cnt++;
    $error("waiting slot used without an in-flight slot");
  end

  // Slot flags follow the outstanding count, which never passes two
  slot_count_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (pending <= 3'd2) && (pending == 3'(valid_inflight_i) + 3'(valid_waiting_i))
  ) else begin
    fail_cnt++;
    $error("outstanding operations do not match the slots");
  end

endmodule

//--- tb/apu_tb.sv
`timescale 1ns/100ps

module apu_tb;

  localparam int DATA_W = apu_pkg::DATA_W;

  // Instructions per test
  localparam int N_LDI   = 16;
  localparam int N_OPS   = 40;
  localparam int N_MIX   = 60;
  localparam int N_CHAIN = 60;
  localparam int N_BUSY  = 60;
  localparam int N_ORDER = 2;
  localparam int N_TOTAL = N_LDI + N_OPS + N_MIX + N_CHAIN + N_BUSY + N_ORDER;
  // Cycles spent in reset before the first word
  localparam int RESET_MARGIN = 10;

  logic                        clk, rst_n;
  logic                        instr_valid, instr_ready;
  logic [31:0]                 instr;
  logic                        apu_busy;
  logic                        wb_valid;
  logic [apu_pkg::REG_AW-1:0]  wb_addr;
  logic [DATA_W-1:0]           wb_data;
  logic                        apu_active;
  logic [15:0]                 perf_type_cnt, perf_cont_cnt;

  // Model register file and expected writebacks in program order
  logic [DATA_W-1:0]           model_regs [apu_pkg::NUM_REGS];
  logic [apu_pkg::REG_AW-1:0]  exp_addr [$];
  logic [DATA_W-1:0]           exp_data [$];

  logic                        busy_en;
  int                          busy_cycles, cycle_cnt;
  logic [15:0]                 type_before;

  apu_tb_clkgen #(.PERIOD_NS(8), .RST_CYCLES(2)) apu_tb_clkgen_i (
    .clk_o(clk),
    .rst_no(rst_n)
  );

  apu_subsys_top #(.DATA_W(DATA_W), .NUM_RD(2), .NUM_WR(1)) apu_subsys_top_i (
    .clk_i(clk), .rst_ni(rst_n),
    .instr_valid_i(instr_valid), .instr_i(instr), .instr_ready_o(instr_ready),
    .apu_busy_i(apu_busy),
    .wb_valid_o(wb_valid), .wb_addr_o(wb_addr), .wb_data_o(wb_data),
    .apu_active_o(apu_active), .perf_type_cnt_o(perf_type_cnt), .perf_cont_cnt_o(perf_cont_cnt)
  );

  bind apu_disp apu_disp_assertions apu_disp_assertions_i (
    .clk_i, .rst_ni, .enable_i, .apu_lat_i, .apu_waddr_i,
    .apu_req_i(apu_req_o), .apu_gnt_i, .apu_rvalid_i,
    .stall_i(stall_o), .valid_inflight_i(valid_inflight), .valid_waiting_i(valid_waiting)
  );

  ////////////////////
  // Reference model
  ////////////////////

  // Result of one operation on model operands
  function automatic logic [DATA_W-1:0] expected_value(input logic [2:0] op,
      input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b, input logic [11:0] imm);
    logic [2*DATA_W-1:0] prod;
    prod = {{DATA_W{1'b0}}, a} * {{DATA_W{1'b0}}, b};
    case (op)
      apu_pkg::LDI:  return DATA_W'(imm);
      apu_pkg::MUL:  return prod[DATA_W-1:0];
      apu_pkg::MULH: return prod[2*DATA_W-1:DATA_W];
      // Zero divisor gives all ones
      apu_pkg::DIVU: return (b == '0) ? '1 : a / b;
      default:       return a + b;
    endcase
  endfunction

  // Run one word over the model and queue its writeback
  function automatic void model_step(input logic [31:0] w);
    logic [2:0]                 op;
    logic [apu_pkg::REG_AW-1:0] rd, rs1, rs2;
    logic [DATA_W-1:0]          res;
    op  = w[apu_pkg::OPC_MSB:apu_pkg::OPC_LSB];
    rd  = w[apu_pkg::RD_MSB:apu_pkg::RD_LSB];
    rs1 = w[apu_pkg::RS1_MSB:apu_pkg::RS1_LSB];
    rs2 = w[apu_pkg::RS2_MSB:apu_pkg::RS2_LSB];
    res = expected_value(op, model_regs[rs1], model_regs[rs2],
                         w[apu_pkg::IMM_MSB:apu_pkg::IMM_LSB]);
    model_regs[rd] = res;
    exp_addr.push_back(rd);
    exp_data.push_back(res);
  endfunction

  ////////////////////
  // Stimulus helpers
  ////////////////////

  // Unused upper bits carry random filler
  function automatic logic [31:0] encode(input logic [2:0] op, input logic [5:0] rd,
                                         input logic [5:0] rs1, input logic [5:0] rs2);
    logic [31:0] w;
    w = $urandom;
    w[apu_pkg::OPC_MSB:apu_pkg::OPC_LSB] = op;
    w[apu_pkg::RD_MSB:apu_pkg::RD_LSB]   = rd;
    w[apu_pkg::RS1_MSB:apu_pkg::RS1_LSB] = rs1;
    w[apu_pkg::RS2_MSB:apu_pkg::RS2_LSB] = rs2;
    return w;
  endfunction

  function automatic logic [31:0] encode_ldi(input logic [5:0] rd, input logic [11:0] imm);
    logic [31:0] w;
    w = encode(apu_pkg::LDI, rd, 6'd0, 6'd0);
    w[apu_pkg::IMM_MSB:apu_pkg::IMM_LSB] = imm;
    return w;
  endfunction

  // Random opcode over the lowest n_regs registers
  function automatic logic [31:0] random_instr(input int n_regs);
    logic [2:0] op;
    op = 3'($urandom % 5);
    if (op == apu_pkg::LDI) begin
      return encode_ldi(6'($urandom % n_regs), 12'($urandom));
    end
    return encode(op, 6'($urandom % n_regs), 6'($urandom % n_regs), 6'($urandom % n_regs));
  endfunction

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic send_instr(input logic [31:0] w);
    logic done;
    done = 1'b0;
    model_step(w);
    instr_valid = 1'b1;
    instr       = w;
    while (!done) begin
      #1;
      done = instr_ready;
      @(negedge clk);
    end
    instr_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_addr.size() != 0 || apu_active) begin
      @(negedge clk);
    end
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %0t: %s got %0h expected %0h", $time, what, got, exp));
    end
  endtask

  ////////////////////
  // Checkers
  ////////////////////

  // Writebacks must match the model in program order
  always @(posedge clk) begin
    if (rst_n && wb_valid) begin
      if (exp_addr.size() == 0) begin
        abort_run("Writeback seen with no instruction left to retire");
      end else begin
        check_value("writeback address", wb_addr, exp_addr.pop_front());
        check_value("writeback data", wb_data, exp_data.pop_front());
      end
    end
  end

  // Dispatcher assertions end the run as soon as one fails
  always @(apu_subsys_top_i.apu_disp_i.apu_disp_assertions_i.fail_cnt) begin
    if (apu_subsys_top_i.apu_disp_i.apu_disp_assertions_i.fail_cnt != 0) begin
      abort_run("A dispatcher assertion failed");
    end
  end

  // Worst case per instruction is a full divide plus pipeline slack
  // Limit also grows with every busy cycle inserted
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > N_TOTAL * (apu_pkg::DIV_CYCLES + 8) + busy_cycles + RESET_MARGIN) begin
      abort_run("Timeout, the design stopped retiring instructions");
    end
  end

  // Random back-pressure, roughly half of the cycles
  always @(negedge clk) begin
    if (busy_en) begin
      apu_busy = ($urandom % 2) != 0;
      if (apu_busy) begin
        busy_cycles++;
      end
    end else begin
      apu_busy = 1'b0;
    end
  end

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    void'($urandom(32'hf781));
    instr_valid = 1'b0;
    instr       = '0;
    apu_busy    = 1'b0;
    busy_en     = 1'b0;
    busy_cycles = 0;
    cycle_cnt   = 0;
    for (int i = 0; i < apu_pkg::NUM_REGS; i++) begin
      model_regs[i] = '0;
    end

    // Idle state right after reset
    @(posedge rst_n);
    #1;
    check_value("ready after reset", instr_ready, 0);
    check_value("active after reset", apu_active, 0);
    check_value("writeback after reset", wb_valid, 0);
    check_value("counters after reset", {perf_type_cnt, perf_cont_cnt}, 0);
    @(negedge clk);
    // Port opens one cycle after reset
    check_value("ready one cycle after reset", instr_ready, 1);

    // Immediates to every fourth register
    for (int k = 0; k < N_LDI; k++) begin
      send_instr(encode_ldi(6'(k * 4 + 1), 12'($urandom)));
    end
    wait_drain();

    // Each operation class on the loaded values
    for (int k = 0; k < N_OPS; k++) begin
      send_instr(encode(3'(1 + k % 4), 6'($urandom % 64),
                        6'(($urandom % 16) * 4 + 1), 6'(($urandom % 16) * 4 + 1)));
    end
    wait_drain();

    // Random mix of latency classes
    for (int k = 0; k < N_MIX; k++) begin
      send_instr(random_instr(64));
    end
    wait_drain();

    // Four registers only, so most words depend on recent ones
    for (int k = 0; k < N_CHAIN; k++) begin
      send_instr(random_instr(4));
    end
    wait_drain();

    // Same kind of traffic under back-pressure
    busy_en = 1'b1;
    for (int k = 0; k < N_BUSY; k++) begin
      send_instr(random_instr(8));
    end
    wait_drain();
    busy_en = 1'b0;
    check_value("no-grant stalls counted", perf_cont_cnt != 16'd0, 1);

    // Short ADD behind a divide must wait for it
    type_before = perf_type_cnt;
    send_instr(encode(apu_pkg::DIVU, 6'd50, 6'd5, 6'd9));
    send_instr(encode(apu_pkg::ADD, 6'd51, 6'd13, 6'd17));
    wait_drain();
    check_value("type stalls counted", perf_type_cnt > type_before, 1);

    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- src.f
hdl/apu_pkg.sv
hdl/apu_decode.sv
hdl/apu_disp.sv
hdl/apu_exec.sv
hdl/apu_result.sv
hdl/apu_subsys_top.sv
tb/apu_tb_clkgen.sv
tb/apu_disp_assertions.sv
tb/apu_tb.sv
